// ==== src/row_buf_pkg.sv ====
`default_nettype none

package row_buf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int PIXEL_WIDTH = 16;
    localparam int COL_WIDTH   = 8;

    // Top address bit picks the row half of a RAM
    localparam int ADDR_WIDTH = COL_WIDTH + 1;
    localparam int RAM_DEPTH  = 1 << ADDR_WIDTH;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel and address types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [PIXEL_WIDTH-1:0] pixel_t;

    // Odd RAM pixel in the upper half, even RAM pixel in the lower half
    typedef logic [2*PIXEL_WIDTH-1:0] pixel_pair_t;

    typedef logic [COL_WIDTH-1:0]  col_t;
    typedef logic [ADDR_WIDTH-1:0] row_addr_t;

endpackage

`default_nettype wire

// ==== src/awe_ctrl_pkg.sv ====
`default_nettype none

package awe_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Layer control
    ////////////////////////////////////////////////////////////////////////////

    // One-hot layer state
    typedef enum logic [5:0] {
        ST_IDLE           = 6'b000001,
        ST_PRIM_BUFFER    = 6'b000010,
        ST_WAIT_PFB_LOAD  = 6'b000100,
        ST_CE_ACTIVE      = 6'b001000,
        ST_FIN_ROW_MATRIC = 6'b010000,
        ST_JOB_DONE       = 6'b100000
    } layer_state_e;

    // Row rotation, one bit per RAM
    typedef logic [1:0] gray_t;

    ////////////////////////////////////////////////////////////////////////////
    // Pixel-sequence word
    ////////////////////////////////////////////////////////////////////////////

    // Half flag on top, then odd column, then even column
    localparam int SEQ_EVEN_MSB = row_buf_pkg::COL_WIDTH - 1;
    localparam int SEQ_ODD_MSB  = 2 * row_buf_pkg::COL_WIDTH - 1;
    localparam int SEQ_HALF_BIT = 2 * row_buf_pkg::COL_WIDTH;

    typedef logic [SEQ_HALF_BIT:0] pix_seq_t;

    // Period of the output cycle counter
    localparam int RENAME_COUNT_MOD = 5;

endpackage

`default_nettype wire

// ==== src/row_ram.sv ====
`default_nettype none

module row_ram (
    input  wire                         clk,
    input  wire                         wr_en,
    input  wire row_buf_pkg::row_addr_t wr_addr,
    input  wire row_buf_pkg::pixel_t    wr_data,
    input  wire                         rd_en,
    input  wire row_buf_pkg::row_addr_t rd_addr,
    output row_buf_pkg::pixel_t         rd_data
);

    // Two row halves of RAM_DEPTH/2 columns each
    row_buf_pkg::pixel_t mem [row_buf_pkg::RAM_DEPTH];
    row_buf_pkg::pixel_t rd_q;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Array read stage
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_q <= mem[rd_addr];
        end
    end

    // Output register, second cycle of read latency
    always_ff @(posedge clk) begin
        rd_data <= rd_q;
    end

endmodule

`default_nettype wire

// ==== src/pix_seq_decode.sv ====
`default_nettype none

module pix_seq_decode (
    input  wire                             clk,
    input  wire                             rst,
    input  wire awe_ctrl_pkg::layer_state_e state,
    input  wire awe_ctrl_pkg::gray_t        gray_code,
    input  wire                             execute,
    input  wire awe_ctrl_pkg::pix_seq_t     pix_seq_datain,
    output row_buf_pkg::row_addr_t          even_addr,
    output row_buf_pkg::row_addr_t          odd_addr,
    output logic                            rd_req
);

    localparam int CW = row_buf_pkg::COL_WIDTH;

    logic              seq_half;
    row_buf_pkg::col_t even_col;
    row_buf_pkg::col_t odd_col;

    // Field split of the sequence word
    assign seq_half = pix_seq_datain[awe_ctrl_pkg::SEQ_HALF_BIT];
    assign even_col = pix_seq_datain[awe_ctrl_pkg::SEQ_EVEN_MSB -: CW];
    assign odd_col  = pix_seq_datain[awe_ctrl_pkg::SEQ_ODD_MSB -: CW];

    // Request only counts while the engine is active
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req <= 1'b0;
        end else begin
            rd_req <= execute && (state == awe_ctrl_pkg::ST_CE_ACTIVE);
        end
    end

    // Each gray bit flips the row half seen by its RAM
    always_ff @(posedge clk) begin
        even_addr <= {seq_half ^ gray_code[0], even_col};
        odd_addr  <= {seq_half ^ gray_code[1], odd_col};
    end

endmodule

`default_nettype wire

// ==== src/row_buf_execute.sv ====
`default_nettype none

module row_buf_execute (
    input  wire                             clk,
    input  wire                             rst,
    input  wire awe_ctrl_pkg::layer_state_e state,
    input  wire awe_ctrl_pkg::gray_t        gray_code,
    input  wire row_buf_pkg::col_t          input_row,
    input  wire row_buf_pkg::col_t          input_col,
    input  wire row_buf_pkg::col_t          num_input_cols,
    input  wire                             pfb_rden,
    input  wire                             last_kernel,
    input  wire                             matric_valid,
    input  wire row_buf_pkg::pixel_t        matric_pixel,
    input  wire row_buf_pkg::col_t          row_matric_addr,
    input  wire row_buf_pkg::row_addr_t     even_addr,
    input  wire row_buf_pkg::row_addr_t     odd_addr,
    input  wire                             rd_req,
    input  wire                             rename_strobe,
    input  wire row_buf_pkg::pixel_t        rename_value,
    output logic                            even_wr_en,
    output row_buf_pkg::row_addr_t          even_wr_addr,
    output row_buf_pkg::pixel_t             even_wr_data,
    output logic                            odd_wr_en,
    output row_buf_pkg::row_addr_t          odd_wr_addr,
    output row_buf_pkg::pixel_t             odd_wr_data,
    output row_buf_pkg::row_addr_t          even_rd_addr,
    output row_buf_pkg::row_addr_t          odd_rd_addr,
    output logic                            rd_issue
);

    logic prim_load;
    logic row_update;
    logic gray_eq;
    logic rd_fire;

    logic                   even_en_d;
    logic                   odd_en_d;
    row_buf_pkg::row_addr_t even_addr_d;
    row_buf_pkg::row_addr_t odd_addr_d;
    row_buf_pkg::pixel_t    even_data_d;
    row_buf_pkg::pixel_t    odd_data_d;

    assign prim_load = (state == awe_ctrl_pkg::ST_PRIM_BUFFER) && pfb_rden
                       && (input_col <= num_input_cols);

    assign row_update = ((state == awe_ctrl_pkg::ST_CE_ACTIVE)
                         || (state == awe_ctrl_pkg::ST_FIN_ROW_MATRIC)) && last_kernel;

    // Equal gray bits put the incoming row in the odd RAM
    assign gray_eq = (gray_code[0] == gray_code[1]);

    assign rd_fire = rd_req && (state == awe_ctrl_pkg::ST_CE_ACTIVE);

    ////////////////////////////////////////////////////////////////////////////
    // Write port selection
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        even_en_d   = 1'b0;
        odd_en_d    = 1'b0;
        even_addr_d = {1'b0, input_col};
        odd_addr_d  = {1'b0, input_col};
        // Load data also comes through the pixel delay line
        even_data_d = matric_pixel;
        odd_data_d  = matric_pixel;

        if (prim_load) begin
            case (input_row)
                row_buf_pkg::col_t'(0): begin
                    even_en_d = 1'b1;
                    odd_en_d  = 1'b1;
                end
                row_buf_pkg::col_t'(1): begin
                    odd_en_d   = 1'b1;
                    odd_addr_d = {1'b1, input_col};
                end
                row_buf_pkg::col_t'(2): begin
                    even_en_d   = 1'b1;
                    even_addr_d = {1'b1, input_col};
                end
                default: ;
            endcase
        end

        // Incoming row of the next tile
        if (row_update && matric_valid) begin
            if (gray_eq) begin
                odd_en_d   = 1'b1;
                odd_addr_d = {gray_code[0], row_matric_addr};
            end else begin
                even_en_d   = 1'b1;
                even_addr_d = {gray_code[0], row_matric_addr};
            end
        end

        // Saved pixel goes to the RAM the row matric leaves alone
        if (row_update && rename_strobe) begin
            if (gray_eq) begin
                even_en_d   = 1'b1;
                even_addr_d = {gray_code[1], row_matric_addr};
                even_data_d = rename_value;
            end else begin
                odd_en_d   = 1'b1;
                odd_addr_d = {gray_code[1], row_matric_addr};
                odd_data_d = rename_value;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Port registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            even_wr_en <= 1'b0;
            odd_wr_en  <= 1'b0;
            rd_issue   <= 1'b0;
        end else begin
            even_wr_en <= even_en_d;
            odd_wr_en  <= odd_en_d;
            rd_issue   <= rd_fire;
        end
    end

    always_ff @(posedge clk) begin
        even_wr_addr <= even_addr_d;
        odd_wr_addr  <= odd_addr_d;
        even_wr_data <= even_data_d;
        odd_wr_data  <= odd_data_d;
        if (rd_fire) begin
            even_rd_addr <= even_addr;
            odd_rd_addr  <= odd_addr;
        end
    end

endmodule

`default_nettype wire

// ==== src/row_rename_result.sv ====
`default_nettype none

module row_rename_result (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      rd_issue,
    input  wire awe_ctrl_pkg::gray_t gray_code,
    input  wire row_buf_pkg::pixel_t even_data,
    input  wire row_buf_pkg::pixel_t odd_data,
    output logic                     pixel_valid,
    output logic                     rename_strobe,
    output row_buf_pkg::pixel_t      rename_value
);

    localparam int CNT_W = $clog2(awe_ctrl_pkg::RENAME_COUNT_MOD);

    typedef logic [CNT_W-1:0] count_t;

    localparam count_t COUNT_LAST = count_t'(awe_ctrl_pkg::RENAME_COUNT_MOD - 1);

    logic   valid_q;
    count_t out_count;
    count_t qual_count;
    logic   take_even;
    logic   qualify;

    // Matches the two-cycle RAM read
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q     <= 1'b0;
            pixel_valid <= 1'b0;
        end else begin
            valid_q     <= rd_issue;
            pixel_valid <= valid_q;
        end
    end

    // Position of each valid output within the sequence period
    always_ff @(posedge clk) begin
        if (rst) begin
            out_count <= '0;
        end else if (pixel_valid) begin
            if (out_count == COUNT_LAST) begin
                out_count <= '0;
            end else begin
                out_count <= out_count + count_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rename capture
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (gray_code)
            2'b00: begin
                qual_count = count_t'(2);
                take_even  = 1'b0;
            end
            2'b01: begin
                qual_count = count_t'(2);
                take_even  = 1'b1;
            end
            2'b11: begin
                qual_count = count_t'(0);
                take_even  = 1'b0;
            end
            default: begin
                qual_count = count_t'(0);
                take_even  = 1'b1;
            end
        endcase
    end

    assign qualify = pixel_valid && (out_count == qual_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            rename_strobe <= 1'b0;
        end else begin
            rename_strobe <= qualify;
        end
    end

    always_ff @(posedge clk) begin
        if (qualify) begin
            rename_value <= take_even ? even_data : odd_data;
        end
    end

endmodule

`default_nettype wire

// ==== src/awe_row_buffers.sv ====
`default_nettype none

module awe_row_buffers #(
    parameter int ROW_MATRIC_DELAY = 1,
    parameter int PIX_IN_DELAY     = 2
) (
    input  wire                             clk,
    input  wire                             rst,
    input  wire awe_ctrl_pkg::layer_state_e state,
    input  wire awe_ctrl_pkg::gray_t        gray_code,
    input  wire row_buf_pkg::col_t          input_row,
    input  wire row_buf_pkg::col_t          input_col,
    input  wire row_buf_pkg::col_t          num_input_cols,
    input  wire                             pfb_rden,
    input  wire                             last_kernel,
    input  wire                             row_matric,
    input  wire                             execute,
    input  wire awe_ctrl_pkg::pix_seq_t     pix_seq_datain,
    input  wire row_buf_pkg::pixel_t        pixel_datain,
    input  wire row_buf_pkg::col_t          row_matric_addr,
    output row_buf_pkg::pixel_pair_t        pixel_dataout,
    output logic                            pixel_valid
);

    logic [ROW_MATRIC_DELAY-1:0] matric_sr;
    row_buf_pkg::pixel_t         pix_sr [PIX_IN_DELAY];

    logic                   matric_valid;
    row_buf_pkg::pixel_t    matric_pixel;
    row_buf_pkg::row_addr_t even_addr;
    row_buf_pkg::row_addr_t odd_addr;
    logic                   rd_req;
    logic                   rd_issue;
    logic                   rename_strobe;
    row_buf_pkg::pixel_t    rename_value;

    logic                   even_wr_en;
    row_buf_pkg::row_addr_t even_wr_addr;
    row_buf_pkg::pixel_t    even_wr_data;
    row_buf_pkg::row_addr_t even_rd_addr;
    row_buf_pkg::pixel_t    even_rd_data;
    logic                   odd_wr_en;
    row_buf_pkg::row_addr_t odd_wr_addr;
    row_buf_pkg::pixel_t    odd_wr_data;
    row_buf_pkg::row_addr_t odd_rd_addr;
    row_buf_pkg::pixel_t    odd_rd_data;

    ////////////////////////////////////////////////////////////////////////////
    // Delay lines for the incoming row
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            matric_sr <= '0;
        end else begin
            matric_sr[0] <= row_matric;
            for (int i = 1; i < ROW_MATRIC_DELAY; i++) begin
                matric_sr[i] <= matric_sr[i-1];
            end
        end
    end

    // Covers prefetch buffer latency
    always_ff @(posedge clk) begin
        pix_sr[0] <= pixel_datain;
        for (int i = 1; i < PIX_IN_DELAY; i++) begin
            pix_sr[i] <= pix_sr[i-1];
        end
    end

    assign matric_valid = matric_sr[ROW_MATRIC_DELAY-1];
    assign matric_pixel = pix_sr[PIX_IN_DELAY-1];

    ////////////////////////////////////////////////////////////////////////////
    // Instances
    ////////////////////////////////////////////////////////////////////////////

    pix_seq_decode u_decode (
        .clk            (clk),
        .rst            (rst),
        .state          (state),
        .gray_code      (gray_code),
        .execute        (execute),
        .pix_seq_datain (pix_seq_datain),
        .even_addr      (even_addr),
        .odd_addr       (odd_addr),
        .rd_req         (rd_req)
    );

    row_buf_execute u_execute (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .gray_code       (gray_code),
        .input_row       (input_row),
        .input_col       (input_col),
        .num_input_cols  (num_input_cols),
        .pfb_rden        (pfb_rden),
        .last_kernel     (last_kernel),
        .matric_valid    (matric_valid),
        .matric_pixel    (matric_pixel),
        .row_matric_addr (row_matric_addr),
        .even_addr       (even_addr),
        .odd_addr        (odd_addr),
        .rd_req          (rd_req),
        .rename_strobe   (rename_strobe),
        .rename_value    (rename_value),
        .even_wr_en      (even_wr_en),
        .even_wr_addr    (even_wr_addr),
        .even_wr_data    (even_wr_data),
        .odd_wr_en       (odd_wr_en),
        .odd_wr_addr     (odd_wr_addr),
        .odd_wr_data     (odd_wr_data),
        .even_rd_addr    (even_rd_addr),
        .odd_rd_addr     (odd_rd_addr),
        .rd_issue        (rd_issue)
    );

    row_ram ram_even (
        .clk     (clk),
        .wr_en   (even_wr_en),
        .wr_addr (even_wr_addr),
        .wr_data (even_wr_data),
        .rd_en   (rd_issue),
        .rd_addr (even_rd_addr),
        .rd_data (even_rd_data)
    );

    row_ram ram_odd (
        .clk     (clk),
        .wr_en   (odd_wr_en),
        .wr_addr (odd_wr_addr),
        .wr_data (odd_wr_data),
        .rd_en   (rd_issue),
        .rd_addr (odd_rd_addr),
        .rd_data (odd_rd_data)
    );

    row_rename_result u_result (
        .clk           (clk),
        .rst           (rst),
        .rd_issue      (rd_issue),
        .gray_code     (gray_code),
        .even_data     (even_rd_data),
        .odd_data      (odd_rd_data),
        .pixel_valid   (pixel_valid),
        .rename_strobe (rename_strobe),
        .rename_value  (rename_value)
    );

    assign pixel_dataout = {odd_rd_data, even_rd_data};

endmodule

`default_nettype wire

// ==== sim/tb_row_buf_model.svh ====
`ifndef TB_ROW_BUF_MODEL_SVH
`define TB_ROW_BUF_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Mirrors of the even and odd row RAMs
////////////////////////////////////////////////////////////////////////////

row_buf_pkg::pixel_t model_even [row_buf_pkg::RAM_DEPTH];
row_buf_pkg::pixel_t model_odd  [row_buf_pkg::RAM_DEPTH];

// Row 0 in both lower halves, row 1 odd upper, row 2 even upper
function automatic void model_load(input int row, input row_buf_pkg::col_t col,
                                   input row_buf_pkg::col_t num_cols,
                                   input row_buf_pkg::pixel_t pix);
    if (col > num_cols) begin
        return;
    end
    case (row)
        0: begin
            model_even[{1'b0, col}] = pix;
            model_odd[{1'b0, col}]  = pix;
        end
        1: model_odd[{1'b1, col}] = pix;
        2: model_even[{1'b1, col}] = pix;
        default: ;
    endcase
endfunction

// Incoming row lands at half gray[0], odd RAM when the gray bits match
function automatic void model_matric(input awe_ctrl_pkg::gray_t g, input row_buf_pkg::col_t col,
                                     input row_buf_pkg::pixel_t pix);
    if (g[0] == g[1]) begin
        model_odd[{g[0], col}] = pix;
    end else begin
        model_even[{g[0], col}] = pix;
    end
endfunction

// Renamed pixel goes to half gray[1] of the other RAM
function automatic void model_rename(input awe_ctrl_pkg::gray_t g, input row_buf_pkg::col_t col,
                                     input row_buf_pkg::pixel_t pix);
    if (g[0] == g[1]) begin
        model_even[{g[1], col}] = pix;
    end else begin
        model_odd[{g[1], col}] = pix;
    end
endfunction

// Codes 00 and 01 capture at count 2, codes 11 and 10 at count 0
function automatic int rename_slot(input awe_ctrl_pkg::gray_t g);
    return g[1] ? 0 : 2;
endfunction

// Even pixel for codes 01 and 10
function automatic row_buf_pkg::pixel_t captured_pixel(input awe_ctrl_pkg::gray_t g,
                                                       input row_buf_pkg::pixel_pair_t pair);
    return (g[0] ^ g[1]) ? pair[15:0] : pair[31:16];
endfunction

////////////////////////////////////////////////////////////////////////////
// Expected pixel pair of one sequence word
////////////////////////////////////////////////////////////////////////////

function automatic row_buf_pkg::pixel_pair_t expected_pair(input awe_ctrl_pkg::pix_seq_t seq,
                                                          input awe_ctrl_pkg::gray_t g);
    logic              half;
    row_buf_pkg::col_t even_col;
    row_buf_pkg::col_t odd_col;
    half     = seq[16];
    odd_col  = seq[15:8];
    even_col = seq[7:0];
    return {model_odd[{half ^ g[1], odd_col}], model_even[{half ^ g[0], even_col}]};
endfunction

`endif

// ==== sim/tb_awe_row_buffers.sv ====
`default_nettype none

module tb_awe_row_buffers;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD       = 10;
    localparam int RESET_CYCLES     = 8;
    localparam int ROW_MATRIC_DELAY = 1;
    localparam int PIX_IN_DELAY     = 2;
    localparam int READ_LATENCY     = 3;
    localparam int NUM_COLS         = 20;
    localparam int LOAD_COLS        = 24;
    localparam int READS            = 16;
    localparam int RENAME_READS     = 12;
    localparam int DRAIN_CYCLES     = 5;
    localparam int MARGIN_CYCLES    = 100;

    // Never loaded, so only the rename writes this column
    localparam row_buf_pkg::col_t RENAME_COL = 8'd30;

    // Budget per section of two loads, plain reads, row matric and rename
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 6 * (LOAD_COLS + PIX_IN_DELAY)
                                     + 4 * (READS + DRAIN_CYCLES + 6)
                                     + 8 * (5 + DRAIN_CYCLES + 6)
                                     + 4 * (RENAME_READS + 2 * (DRAIN_CYCLES + 6) + 1)
                                     + MARGIN_CYCLES;

    logic                       clk;
    logic                       rst;
    awe_ctrl_pkg::layer_state_e state;
    awe_ctrl_pkg::gray_t        gray_code;
    row_buf_pkg::col_t          input_row;
    row_buf_pkg::col_t          input_col;
    row_buf_pkg::col_t          num_input_cols;
    logic                       pfb_rden;
    logic                       last_kernel;
    logic                       row_matric;
    logic                       execute;
    awe_ctrl_pkg::pix_seq_t     pix_seq_datain;
    row_buf_pkg::pixel_t        pixel_datain;
    row_buf_pkg::col_t          row_matric_addr;
    row_buf_pkg::pixel_pair_t   pixel_dataout;
    logic                       pixel_valid;

    awe_ctrl_pkg::gray_t      gray_seq [4] = '{2'b00, 2'b01, 2'b11, 2'b10};
    logic [31:0]              rng_state     = 32'd28;
    int                       cycle_count   = 0;
    int                       valid_count   = 0;
    int                       capture_count = 0;
    bit                       rename_active = 1'b0;
    row_buf_pkg::pixel_t      last_capture;
    row_buf_pkg::pixel_pair_t exp_q [$];
    int                       issue_q [$];

    `include "tb_row_buf_model.svh"

    ////////////////////////////////////////////////////////////////////////////
    // Random stimulus
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic row_buf_pkg::pixel_t random_pixel();
        return row_buf_pkg::pixel_t'(next_random());
    endfunction

    // Only loaded columns
    function automatic row_buf_pkg::col_t random_col();
        return row_buf_pkg::col_t'(next_random() % LOAD_COLS);
    endfunction

    function automatic awe_ctrl_pkg::pix_seq_t random_seq();
        logic [31:0] r;
        r = next_random();
        return {r[0], random_col(), random_col()};
    endfunction

    // Sequence word that reads row half want_half of one RAM at col
    function automatic awe_ctrl_pkg::pix_seq_t seq_for(input bit on_odd, input logic want_half,
                                                       input row_buf_pkg::col_t col,
                                                       input row_buf_pkg::col_t other,
                                                       input awe_ctrl_pkg::gray_t g);
        logic h;
        h = want_half ^ (on_odd ? g[1] : g[0]);
        if (on_odd) begin
            return {h, col, other};
        end
        return {h, other, col};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks and drive tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic issue_read(input awe_ctrl_pkg::pix_seq_t seq);
        wait_cycle();
        execute        = 1'b1;
        pix_seq_datain = seq;
        exp_q.push_back(expected_pair(seq, gray_code));
        issue_q.push_back(cycle_count + 1);
    endtask

    // Lets all reads and any rename write settle
    task automatic end_reads();
        wait_cycle();
        execute = 1'b0;
        while (exp_q.size() != 0) begin
            wait_cycle();
        end
        repeat (DRAIN_CYCLES) wait_cycle();
    endtask

    // Control trails the pixel stream by the pixel delay line
    task automatic load_rows(input row_buf_pkg::col_t num_cols);
        row_buf_pkg::pixel_t pix [LOAD_COLS];
        state          = awe_ctrl_pkg::ST_PRIM_BUFFER;
        num_input_cols = num_cols;
        for (int r = 0; r < 3; r++) begin
            for (int c = 0; c < LOAD_COLS; c++) begin
                pix[c] = random_pixel();
            end
            for (int t = 0; t < LOAD_COLS + PIX_IN_DELAY; t++) begin
                wait_cycle();
                if (t < LOAD_COLS) begin
                    pixel_datain = pix[t];
                end
                pfb_rden = (t >= PIX_IN_DELAY);
                if (t >= PIX_IN_DELAY) begin
                    input_row = row_buf_pkg::col_t'(r);
                    input_col = row_buf_pkg::col_t'(t - PIX_IN_DELAY);
                    model_load(r, input_col, num_input_cols, pix[t - PIX_IN_DELAY]);
                end
            end
        end
        wait_cycle();
        pfb_rden = 1'b0;
    endtask

    // Pixel one cycle ahead of row_matric, write two edges after row_matric
    task automatic matric_write(input row_buf_pkg::col_t addr, input row_buf_pkg::pixel_t pix,
                                input logic kernel_last);
        wait_cycle();
        pixel_datain    = pix;
        row_matric_addr = addr;
        last_kernel     = kernel_last;
        wait_cycle();
        row_matric = 1'b1;
        wait_cycle();
        row_matric = 1'b0;
        wait_cycle();
        last_kernel = 1'b0;
        if (kernel_last) begin
            model_matric(gray_code, addr, pix);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // DUT, clock and watchdog
    ////////////////////////////////////////////////////////////////////////////

    awe_row_buffers #(
        .ROW_MATRIC_DELAY (ROW_MATRIC_DELAY),
        .PIX_IN_DELAY     (PIX_IN_DELAY)
    ) i_dut (
        .clk             (clk),
        .rst             (rst),
        .state           (state),
        .gray_code       (gray_code),
        .input_row       (input_row),
        .input_col       (input_col),
        .num_input_cols  (num_input_cols),
        .pfb_rden        (pfb_rden),
        .last_kernel     (last_kernel),
        .row_matric      (row_matric),
        .execute         (execute),
        .pix_seq_datain  (pix_seq_datain),
        .pixel_datain    (pixel_datain),
        .row_matric_addr (row_matric_addr),
        .pixel_dataout   (pixel_dataout),
        .pixel_valid     (pixel_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Timeout: watchdog expired after %0d cycles", WATCHDOG_CYCLES);
        $display("Simulation failed");
        $fatal(1, "watchdog");
    end

    // Outputs sampled mid-cycle
    always @(negedge clk) begin : compare
        row_buf_pkg::pixel_pair_t exp_val;
        int                       issued;
        if (cycle_count > 0 && pixel_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: pixel_valid is high with no read outstanding", $time);
                $display("Simulation failed");
                $fatal(1, "unexpected valid");
            end else begin
                exp_val = exp_q.pop_front();
                issued  = issue_q.pop_front();
                check_value("pixel_dataout", pixel_dataout, exp_val);
                check_value("pixel_valid latency", 32'(cycle_count - issued), 32'(READ_LATENCY));
                if (rename_active && valid_count == rename_slot(gray_code)) begin
                    last_capture  = captured_pixel(gray_code, exp_val);
                    capture_count = capture_count + 1;
                end
                valid_count = (valid_count + 1) % awe_ctrl_pkg::RENAME_COUNT_MOD;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int                 captures;
        row_buf_pkg::col_t  col_a;
        awe_ctrl_pkg::pix_seq_t seq;
        rst             = 1'b1;
        state           = awe_ctrl_pkg::ST_IDLE;
        gray_code       = 2'b00;
        input_row       = '0;
        input_col       = '0;
        num_input_cols  = row_buf_pkg::col_t'(NUM_COLS);
        pfb_rden        = 1'b0;
        last_kernel     = 1'b0;
        row_matric      = 1'b0;
        execute         = 1'b0;
        pix_seq_datain  = '0;
        pixel_datain    = '0;
        row_matric_addr = '0;
        repeat (RESET_CYCLES) wait_cycle();
        rst = 1'b0;
        repeat (4) wait_cycle();

        // Full rows first, so the skipped columns keep known pixels
        load_rows(row_buf_pkg::col_t'(LOAD_COLS - 1));
        load_rows(row_buf_pkg::col_t'(NUM_COLS));
        state = awe_ctrl_pkg::ST_CE_ACTIVE;

        // Plain reads, gray code 00 first
        for (int gi = 0; gi < 4; gi++) begin
            gray_code = gray_seq[gi];
            repeat (READS) issue_read(random_seq());
            end_reads();
        end

        // Row matric with and without the last kernel
        for (int gi = 0; gi < 4; gi++) begin
            gray_code = gray_seq[gi];
            col_a     = random_col();
            seq = seq_for(gray_code[0] == gray_code[1], gray_code[0], col_a, random_col(),
                          gray_code);
            matric_write(col_a, random_pixel(), 1'b1);
            issue_read(seq);
            end_reads();
            matric_write(col_a, random_pixel(), 1'b0);
            issue_read(seq);
            end_reads();
        end

        // Rename runs, then read back the renamed word
        row_matric_addr = RENAME_COL;
        for (int gi = 0; gi < 4; gi++) begin
            gray_code     = gray_seq[gi];
            last_kernel   = 1'b1;
            rename_active = 1'b1;
            captures      = capture_count;
            repeat (RENAME_READS) issue_read(random_seq());
            end_reads();
            rename_active = 1'b0;
            last_kernel   = 1'b0;
            if (capture_count != captures) begin
                model_rename(gray_code, RENAME_COL, last_capture);
            end
            issue_read(seq_for(gray_code[0] != gray_code[1], gray_code[1], RENAME_COL,
                               random_col(), gray_code));
            end_reads();
        end

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+sim
src/row_buf_pkg.sv
src/awe_ctrl_pkg.sv
src/row_ram.sv
src/pix_seq_decode.sv
src/row_buf_execute.sv
src/row_rename_result.sv
src/awe_row_buffers.sv
sim/tb_awe_row_buffers.sv

// ==== Makefile ====
# Verilator build and run of the row buffer testbench

VERILATOR ?= verilator
TOP       ?= tb_awe_row_buffers
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= Simulation passed
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, whatever the exit code of the pipe
run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Pass message not found in $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
